/* common/tcb_lite_pkg.sv */
package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////////////////////////

    // data bus width in bits
    localparam int unsigned DAT_WIDTH = 32;

    // bytes per data word
    localparam int unsigned BYT = DAT_WIDTH / 8;

    // byte address width, 1 KiB address space
    localparam int unsigned ADR_WIDTH = 10;

    // low address bits that select a byte inside a word
    localparam int unsigned OFF_WIDTH = $clog2(BYT);

    // memory depth in words
    localparam int unsigned MEM_WORDS = 2**(ADR_WIDTH - OFF_WIDTH);

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    typedef logic [ADR_WIDTH-1:0] adr_t;
    typedef logic [DAT_WIDTH-1:0] dat_t;
    typedef logic [BYT-1:0]       byt_t;

    // log2 of transfer size in bytes, 3 is not legal
    typedef logic [1:0] siz_t;

    // word index into the memory array
    typedef logic [ADR_WIDTH-OFF_WIDTH-1:0] widx_t;

    ////////////////////////////////////////////////////////////
    // request structs
    ////////////////////////////////////////////////////////////

    // log-size request, write data right-aligned
    typedef struct packed {
        logic wen;
        adr_t adr;
        siz_t siz;
        dat_t wdt;
    } lsize_req_t;

    // byte-enable request, write data already in lanes
    typedef struct packed {
        logic wen;
        adr_t adr;
        byt_t byt;
        dat_t wdt;
    } bena_req_t;

    // memory side request, word indexed
    typedef struct packed {
        logic  wen;
        widx_t idx;
        byt_t  byt;
        dat_t  wdt;
    } mem_req_t;

endpackage

/* verilog/tcb_lite_lsize_align.sv */
module tcb_lite_lsize_align (
    input  logic                      tcb,
    input  logic                      rst,
    // log-size manager side
    input  logic                      vld,
    input  tcb_lite_pkg::lsize_req_t  req,
    output logic                      rdy,
    output tcb_lite_pkg::dat_t        rdt,
    // byte-enable bus side
    output logic                      bus_vld,
    output tcb_lite_pkg::bena_req_t   bus_req,
    input  logic                      bus_rdy,
    input  tcb_lite_pkg::dat_t        bus_rdt
);

    // byte offset of the current request
    logic [tcb_lite_pkg::OFF_WIDTH-1:0] off;
    // offset and size of the last transfer, for the response
    logic [tcb_lite_pkg::OFF_WIDTH-1:0] off_q;
    tcb_lite_pkg::siz_t                 siz_q;
    // size pattern before shifting into place
    tcb_lite_pkg::byt_t                 msk;
    // natural alignment and legal size
    logic                               legal;

    ////////////////////////////////////////////////////////////
    // request path
    ////////////////////////////////////////////////////////////

    assign off     = req.adr[tcb_lite_pkg::OFF_WIDTH-1:0];
    assign bus_vld = vld;
    assign rdy     = bus_rdy;

    always_comb begin
        case (req.siz)
            2'd0:    msk = tcb_lite_pkg::byt_t'(1);
            2'd1:    msk = tcb_lite_pkg::byt_t'(3);
            default: msk = '1;
        endcase
        // size must divide the address
        case (req.siz)
            2'd0:    legal = 1'b1;
            2'd1:    legal = ~off[0];
            2'd2:    legal = (off == '0);
            default: legal = 1'b0;
        endcase
        bus_req.wen = req.wen;
        bus_req.adr = req.adr;
        bus_req.byt = msk << off;
        // rotate right-aligned data up into its lanes
        for (int b = 0; b < tcb_lite_pkg::BYT; b++) begin
            bus_req.wdt[8*b +: 8] = req.wdt[8*((b + tcb_lite_pkg::BYT - int'(off))
                                                % tcb_lite_pkg::BYT) +: 8];
        end
    end

    ////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////

    // remember where the read data sits
    always_ff @(posedge tcb) begin
        if (rst) begin
            off_q <= '0;
            siz_q <= '0;
        end else if (vld && bus_rdy) begin
            off_q <= off;
            siz_q <= req.siz;
        end
    end

    // shift lanes down, zero bytes past the size
    always_comb begin
        for (int b = 0; b < tcb_lite_pkg::BYT; b++) begin
            if (b < (1 << siz_q)) begin
                rdt[8*b +: 8] = bus_rdt[8*((b + int'(off_q)) % tcb_lite_pkg::BYT) +: 8];
            end else begin
                rdt[8*b +: 8] = 8'h00;
            end
        end
    end

    // no word crossing, no size 3
    aligned_transfer: assert property (
        @(posedge tcb) disable iff (rst)
        (vld && bus_rdy) |-> legal
    ) else $error("misaligned or illegal size transfer on log-size port");

endmodule

/* verilog/tcb_lite_arbiter.sv */
module tcb_lite_arbiter (
    input  logic                          tcb,
    input  logic                          rst,
    // manager side, port 0 and port 1
    input  logic [1:0]                    vld,
    input  tcb_lite_pkg::bena_req_t [1:0] req,
    output logic [1:0]                    rdy,
    output tcb_lite_pkg::dat_t            rdt,
    // memory side
    output logic                          mem_trn,
    output tcb_lite_pkg::mem_req_t        mem_req,
    input  tcb_lite_pkg::dat_t            mem_rdt
);

    // port granted on the last transfer
    logic       lst;
    // grant vector for this cycle
    logic [1:0] gnt;
    // index of the granted port
    logic       sel;

    ////////////////////////////////////////////////////////////
    // round-robin grant
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (vld[0] && vld[1]) begin
            // contention goes to the port that did not win last
            gnt = lst ? 2'b01 : 2'b10;
        end else begin
            // single requester passes straight through
            gnt = vld;
        end
    end

    assign sel     = gnt[1];
    assign rdy     = gnt;
    assign mem_trn = |gnt;

    // starts at port 1 so port 0 wins the first contention
    always_ff @(posedge tcb) begin
        if (rst) begin
            lst <= 1'b1;
        end else if (mem_trn) begin
            lst <= sel;
        end
    end

    ////////////////////////////////////////////////////////////
    // request mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        mem_req.wen = req[sel].wen;
        // drop byte offset, keep word index
        mem_req.idx = req[sel].adr[tcb_lite_pkg::ADR_WIDTH-1:tcb_lite_pkg::OFF_WIDTH];
        mem_req.byt = req[sel].byt;
        mem_req.wdt = req[sel].wdt;
    end

    // shared by both managers
    // only the owner of the last read samples it
    assign rdt = mem_rdt;

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // one transfer per edge at most
    rdy_exclusive: assert property (
        @(posedge tcb) disable iff (rst)
        !(rdy[0] && rdy[1])
    ) else $error("both arbiter ports ready in the same cycle");

    // a waiting port loses at most once in a row
    for (genvar i = 0; i < 2; i++) begin : g_fair
        no_starve: assert property (
            @(posedge tcb) disable iff (rst)
            (vld[i] && !rdy[i]) |=> (!vld[i] || rdy[i])
        ) else $error("arbiter port %0d held off for two cycles", i);
    end

endmodule

/* memory/tcb_lite_memory.sv */
module tcb_lite_memory (
    input  logic                   tcb,
    // transfer strobe from the arbiter
    input  logic                   trn,
    input  tcb_lite_pkg::mem_req_t req,
    output tcb_lite_pkg::dat_t     rdt
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // word array split into byte lanes
    logic [tcb_lite_pkg::BYT-1:0][7:0] mem [tcb_lite_pkg::MEM_WORDS];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    // masked write, one lane per enable bit
    always_ff @(posedge tcb) begin
        if (trn && req.wen) begin
            for (int b = 0; b < tcb_lite_pkg::BYT; b++) begin
                if (req.byt[b]) begin
                    mem[req.idx][b] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // whole word is read, lanes are picked by the manager
    // holds between reads
    always_ff @(posedge tcb) begin
        if (trn && !req.wen) begin
            rdt <= mem[req.idx];
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // an empty byte mask means a broken converter upstream
    byt_nonzero: assert property (
        @(posedge tcb)
        trn |-> (req.byt != '0)
    ) else $error("memory transfer with no byte enabled");

endmodule

/* verilog/tcb_lite_shared_memory.sv */
module tcb_lite_shared_memory (
    input  logic                     tcb,
    input  logic                     rst,
    // manager a, log-size requests
    input  logic                     a_vld,
    input  tcb_lite_pkg::lsize_req_t a_req,
    output logic                     a_rdy,
    output tcb_lite_pkg::dat_t       a_rdt,
    // manager b, byte-enable requests
    input  logic                     b_vld,
    input  tcb_lite_pkg::bena_req_t  b_req,
    output logic                     b_rdy,
    output tcb_lite_pkg::dat_t       b_rdt
);

    // converted manager a bus
    logic                                aln_vld;
    tcb_lite_pkg::bena_req_t             aln_req;
    // arbiter inputs, port 0 is manager a
    logic [1:0]                          arb_vld;
    tcb_lite_pkg::bena_req_t [1:0]       arb_req;
    logic [1:0]                          arb_rdy;
    tcb_lite_pkg::dat_t                  arb_rdt;
    // memory port
    logic                                mem_trn;
    tcb_lite_pkg::mem_req_t              mem_req;
    tcb_lite_pkg::dat_t                  mem_rdt;

    ////////////////////////////////////////////////////////////
    // manager a size to byte-enable conversion
    ////////////////////////////////////////////////////////////

    tcb_lite_lsize_align align (
        .tcb     (tcb),
        .rst     (rst),
        .vld     (a_vld),
        .req     (a_req),
        .rdy     (a_rdy),
        .rdt     (a_rdt),
        .bus_vld (aln_vld),
        .bus_req (aln_req),
        .bus_rdy (arb_rdy[0]),
        .bus_rdt (arb_rdt)
    );

    ////////////////////////////////////////////////////////////
    // arbitration and memory
    ////////////////////////////////////////////////////////////

    assign arb_vld = {b_vld, aln_vld};
    assign arb_req = {b_req, aln_req};
    assign b_rdy   = arb_rdy[1];
    // same response word goes to both managers
    assign b_rdt   = arb_rdt;

    tcb_lite_arbiter arbiter (
        .tcb     (tcb),
        .rst     (rst),
        .vld     (arb_vld),
        .req     (arb_req),
        .rdy     (arb_rdy),
        .rdt     (arb_rdt),
        .mem_trn (mem_trn),
        .mem_req (mem_req),
        .mem_rdt (mem_rdt)
    );

    tcb_lite_memory memory (
        .tcb (tcb),
        .trn (mem_trn),
        .req (mem_req),
        .rdt (mem_rdt)
    );

endmodule

/* tests/tcb_lite_shared_memory_checker.sv */
module tcb_lite_shared_memory_checker (
    input  logic                     tcb,
    input  logic                     rst,
    input  logic                     a_vld,
    input  tcb_lite_pkg::lsize_req_t a_req,
    input  logic                     a_rdy,
    input  tcb_lite_pkg::dat_t       a_rdt,
    input  logic                     b_vld,
    input  tcb_lite_pkg::bena_req_t  b_req,
    input  logic                     b_rdy,
    input  tcb_lite_pkg::dat_t       b_rdt,
    output int                       errors,
    output int                       transfers
);
    timeunit 1ns;
    timeprecision 1ps;

    // byte shadow of the whole address space
    logic [7:0]         shadow [2**tcb_lite_pkg::ADR_WIDTH];
    // last granted port where 1 is b
    logic               lst;
    // read transferred on the last edge
    logic               a_pend = 1'b0;
    logic               b_pend = 1'b0;
    tcb_lite_pkg::dat_t a_exp;
    tcb_lite_pkg::dat_t b_exp;
    tcb_lite_pkg::dat_t b_msk;
    int                 bus_errors = 0;
    int                 data_errors = 0;
    int                 count = 0;

    assign errors    = bus_errors + data_errors;
    assign transfers = count;

    ////////////////////////////////////////////////////////////
    // transfer monitor and shadow update
    ////////////////////////////////////////////////////////////

    always @(posedge tcb) begin
        tcb_lite_pkg::adr_t p;
        logic               a_gnt;
        logic               b_gnt;
        a_pend = 1'b0;
        b_pend = 1'b0;
        if (rst) begin
            lst = 1'b1;
        end else begin
            if (a_rdy && b_rdy) begin
                $display("error at %0d ns: both ports ready in one cycle", $time);
                bus_errors++;
            end
            // a lone request is granted at once
            // contention goes to the port not granted last
            a_gnt = a_vld && (!b_vld || lst);
            b_gnt = b_vld && (!a_vld || !lst);
            if (a_rdy !== a_gnt) begin
                $display("[FAIL] %0d ns a_rdy expected %b actual %b", $time, a_gnt, a_rdy);
                bus_errors++;
            end
            if (b_rdy !== b_gnt) begin
                $display("[FAIL] %0d ns b_rdy expected %b actual %b", $time, b_gnt, b_rdy);
                bus_errors++;
            end
            if (a_vld && a_rdy) begin
                count++;
                lst   = 1'b0;
                a_exp = '0;
                // right-aligned bytes with upper ones left zero
                for (int i = 0; i < (1 << a_req.siz); i++) begin
                    p = a_req.adr + tcb_lite_pkg::adr_t'(i);
                    if (a_req.wen) begin
                        shadow[p] = a_req.wdt[8*i +: 8];
                    end else begin
                        a_exp[8*i +: 8] = shadow[p];
                    end
                end
                a_pend = !a_req.wen;
            end
            if (b_vld && b_rdy) begin
                count++;
                lst   = 1'b1;
                b_exp = '0;
                b_msk = '0;
                // lanes map straight onto word bytes
                for (int l = 0; l < tcb_lite_pkg::BYT; l++) begin
                    p = {b_req.adr[tcb_lite_pkg::ADR_WIDTH-1:2], 2'(l)};
                    if (b_req.byt[l] && b_req.wen) begin
                        shadow[p] = b_req.wdt[8*l +: 8];
                    end else if (b_req.byt[l]) begin
                        b_exp[8*l +: 8] = shadow[p];
                        b_msk[8*l +: 8] = 8'hff;
                    end
                end
                b_pend = !b_req.wen;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read data compare at mid cycle after the transfer
    ////////////////////////////////////////////////////////////

    always @(negedge tcb) begin
        if (a_pend && (a_rdt !== a_exp)) begin
            $display("[FAIL] %0d ns a_rdt expected %h actual %h", $time, a_exp, a_rdt);
            data_errors++;
        end
        // enabled lanes only
        if (b_pend && ((b_rdt & b_msk) !== b_exp)) begin
            $display("[FAIL] %0d ns b_rdt expected %h actual %h", $time, b_exp, b_rdt & b_msk);
            data_errors++;
        end
    end

endmodule

/* tests/tcb_lite_shared_memory_tb.sv */
module tcb_lite_shared_memory_tb;
    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    // per port operation of a row
    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] WR   = 2'd1;
    localparam logic [1:0] RND  = 2'd2;
    localparam logic [1:0] RD   = 2'd3;

    // RND writes LFSR data, the table word is ignored
    typedef struct packed {
        logic [1:0]         a_op;
        tcb_lite_pkg::adr_t a_adr;
        tcb_lite_pkg::siz_t a_siz;
        tcb_lite_pkg::dat_t a_wdt;
        logic [1:0]         b_op;
        tcb_lite_pkg::adr_t b_adr;
        tcb_lite_pkg::byt_t b_byt;
        tcb_lite_pkg::dat_t b_wdt;
    } row_t;

    localparam int ROWS = 21;

    // a: op, adr, siz, wdt | b: op, adr, byt, wdt
    localparam row_t TBL [ROWS] = '{
        // first contention right after reset, then every size and offset on a
        '{WR,   10'h000, 2'd2, 32'h44332211, WR,   10'h010, 4'hf, 32'h01234567},
        '{RD,   10'h000, 2'd0, 32'h0,        IDLE, 10'h000, 4'h0, 32'h0},
        '{RD,   10'h001, 2'd0, 32'h0,        IDLE, 10'h000, 4'h0, 32'h0},
        '{RD,   10'h002, 2'd0, 32'h0,        IDLE, 10'h000, 4'h0, 32'h0},
        '{RD,   10'h003, 2'd0, 32'h0,        IDLE, 10'h000, 4'h0, 32'h0},
        '{RD,   10'h000, 2'd1, 32'h0,        IDLE, 10'h000, 4'h0, 32'h0},
        '{RD,   10'h002, 2'd1, 32'h0,        RD,   10'h010, 4'hf, 32'h0},
        // byte writes on a, partial lanes on b
        '{WR,   10'h004, 2'd0, 32'h000000a5, WR,   10'h010, 4'h5, 32'hffeeddcc},
        '{WR,   10'h005, 2'd0, 32'h0000005a, RD,   10'h010, 4'hf, 32'h0},
        '{WR,   10'h006, 2'd0, 32'h00000077, IDLE, 10'h000, 4'h0, 32'h0},
        '{WR,   10'h007, 2'd0, 32'h00000088, RD,   10'h000, 4'h6, 32'h0},
        '{RD,   10'h004, 2'd2, 32'h0,        RD,   10'h004, 4'hf, 32'h0},
        // halfwords, then reads through the other port
        '{WR,   10'h008, 2'd1, 32'h0000beef, WR,   10'h024, 4'hf, 32'h89abcdef},
        '{WR,   10'h00a, 2'd1, 32'h0000cafe, RD,   10'h024, 4'h8, 32'h0},
        '{RD,   10'h00a, 2'd1, 32'h0,        RD,   10'h008, 4'hf, 32'h0},
        '{RD,   10'h024, 2'd2, 32'h0,        RD,   10'h008, 4'hc, 32'h0},
        // random data at both ends of the address space
        '{RND,  10'h3fc, 2'd2, 32'h0,        RND,  10'h000, 4'hf, 32'h0},
        '{RND,  10'h3ff, 2'd0, 32'h0,        RND,  10'h200, 4'ha, 32'h0},
        '{RD,   10'h3fc, 2'd2, 32'h0,        RD,   10'h000, 4'hf, 32'h0},
        '{RD,   10'h000, 2'd2, 32'h0,        RD,   10'h3fc, 4'hf, 32'h0},
        '{RD,   10'h3fe, 2'd1, 32'h0,        RD,   10'h200, 4'ha, 32'h0}
    };

    logic                     tcb = 1'b0;
    logic                     rst = 1'b1;
    logic                     a_vld = 1'b0;
    tcb_lite_pkg::lsize_req_t a_req = '0;
    logic                     a_rdy;
    tcb_lite_pkg::dat_t       a_rdt;
    logic                     b_vld = 1'b0;
    tcb_lite_pkg::bena_req_t  b_req = '0;
    logic                     b_rdy;
    tcb_lite_pkg::dat_t       b_rdt;
    // counts from the checker
    int                       errors;
    int                       transfers;
    // lfsr state, seed 30
    logic [31:0]              lfsr = 32'd30;
    int                       count_errors = 0;

    always #10 tcb = ~tcb;

    tcb_lite_shared_memory uut (.*);
    tcb_lite_shared_memory_checker chk (.*);

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // one galois step per bit, taps x^32+x^22+x^2+x+1
    function automatic tcb_lite_pkg::dat_t random_word();
        tcb_lite_pkg::dat_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w    = {w[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return w;
    endfunction

    task automatic apply_row(input row_t row);
        a_vld = (row.a_op != IDLE);
        b_vld = (row.b_op != IDLE);
        a_req = '{(row.a_op == WR) || (row.a_op == RND), row.a_adr, row.a_siz, row.a_wdt};
        b_req = '{(row.b_op == WR) || (row.b_op == RND), row.b_adr, row.b_byt, row.b_wdt};
        // port a draws from the lfsr first
        if (row.a_op == RND) begin
            a_req.wdt = random_word();
        end
        if (row.b_op == RND) begin
            b_req.wdt = random_word();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // driving loop
    ////////////////////////////////////////////////////////////

    initial begin
        int   expected;
        logic a_acc;
        logic b_acc;
        expected = 0;
        repeat (3) @(posedge tcb);
        @(negedge tcb);
        rst = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            apply_row(TBL[r]);
            expected = expected + int'(a_vld) + int'(b_vld);
            // hold each request until a rising edge with rdy
            while (a_vld || b_vld) begin
                @(posedge tcb);
                a_acc = a_vld && a_rdy;
                b_acc = b_vld && b_rdy;
                @(negedge tcb);
                a_vld = a_vld && !a_acc;
                b_vld = b_vld && !b_acc;
            end
        end
        // last read response still to be compared
        repeat (2) @(negedge tcb);
        if (transfers != expected) begin
            $display("error: %0d transfers seen but the table requested %0d",
                     transfers, expected);
            count_errors++;
        end
        $display("errors %0d, transfers %0d", errors + count_errors, transfers);
        if (errors + count_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // about four cycles per row plus reset and drain
    initial begin
        #((ROWS * 4 + 20) * 20);
        $display("error: watchdog expired before the table was done");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* tcb_lite_shared_memory.f */
common/tcb_lite_pkg.sv
verilog/tcb_lite_lsize_align.sv
verilog/tcb_lite_arbiter.sv
memory/tcb_lite_memory.sv
verilog/tcb_lite_shared_memory.sv
tests/tcb_lite_shared_memory_checker.sv
tests/tcb_lite_shared_memory_tb.sv

/* run.sh */
#!/bin/sh
# build and run the shared memory testbench with Verilator
# the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps \
    --top-module tcb_lite_shared_memory_tb \
    -f tcb_lite_shared_memory.f \
    && ./obj_dir/Vtcb_lite_shared_memory_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
